// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int data_w     = 128; // one beat
  localparam int strb_w     = 16;  // one strobe bit per byte
  localparam int mem_addr_w = 8;   // words kept per frame slot
  localparam int fifo_depth = 8;   // every stream FIFO

  // occupancy width for a fifo_depth FIFO, 0..fifo_depth
  localparam int cnt_w = $clog2(fifo_depth + 1);

  // write beat, data over strobe as the writer packs it
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
  } wr_beat_t;

  // read beat back to the consumer
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              last; // echoed from the request
  } rd_beat_t;

endpackage

`default_nettype wire

// ==== frame_pkg.sv ====
`default_nettype none

package frame_pkg;

  localparam int addr_w = 22; // external word address

  typedef logic slot_t; // ping-pong frame slot

  // write address, slot taken from frame_in at acceptance
  typedef struct packed {
    slot_t             slot;
    logic [addr_w-1:0] addr;
  } wr_addr_t;

  // read request, slot is chosen inside the controller
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              last; // tag returned with the beat
  } rd_req_t;

  // word address as seen by the memory
  typedef struct packed {
    slot_t                           slot;
    logic [mem_pkg::mem_addr_w-1:0] word; // truncated word address
  } mem_word_t;

endpackage

`default_nettype wire

// ==== beat_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 8
) (
  input  wire                          clk_ui,
  input  wire                          rst_n,
  input  wire payload_t                in_data,
  input  wire                          in_valid,
  output logic                         in_ready,
  output payload_t                     out_data,
  output logic                         out_valid,
  input  wire                          out_ready,
  output logic [$clog2(depth+1)-1:0]   count
);

  payload_t                   mem [depth];  // payload storage
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic                       active_q;     // high from the cycle after reset
  logic                       push;
  logic                       pop;

  assign in_ready  = active_q && (count != ($clog2(depth+1))'(depth)); // low when full
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr]; // head is always visible

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk_ui) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk_ui) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (push) begin
        // wraps at depth even when not a power of two
        wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  // occupancy stays in range across any push/pop sequence
  a_count_range: assert property (
    @(posedge clk_ui) disable iff (!rst_n)
    count <= ($clog2(depth+1))'(depth)
  );

endmodule

`default_nettype wire

// ==== buffer_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module buffer_ctrl (
  input  wire                          clk_ui,
  input  wire                          rst_n,
  input  wire                          frame_in,
  input  wire frame_pkg::wr_addr_t     wa_data,
  input  wire                          wa_valid,
  output logic                         wa_ready,
  input  wire mem_pkg::wr_beat_t       wd_data,
  input  wire                          wd_valid,
  output logic                         wd_ready,
  input  wire frame_pkg::rd_req_t      rd_req,
  input  wire                          ar_valid,
  output logic                         ar_ready,
  input  wire [mem_pkg::cnt_w-1:0]     rfifo_count,
  output logic                         mem_we,
  output frame_pkg::mem_word_t         mem_waddr,
  output mem_pkg::wr_beat_t            mem_wbeat,
  output logic                         mem_re,
  output frame_pkg::mem_word_t         mem_raddr,
  output logic                         mem_rlast
);

  frame_pkg::slot_t            frame_q1;    // first sync flop
  frame_pkg::slot_t            frame_sync;  // second sync flop, safe to use
  logic                        run_q;       // reads allowed from cycle after reset
  logic                        prefer_rd;   // round-robin bit, 1 = read wins a tie
  logic                        inflight_q;  // read issued last cycle, beat on its way
  logic [mem_pkg::cnt_w:0]     credit_used; // in flight + parked in read FIFO
  logic                        credit_ok;
  logic                        wr_pend;
  logic                        rd_pend;
  logic                        wr_go;
  logic                        rd_go;

  // reads owed to the read FIFO
  assign credit_used = {{mem_pkg::cnt_w{1'b0}}, inflight_q} + {1'b0, rfifo_count};
  assign credit_ok   = credit_used < (mem_pkg::cnt_w + 1)'(mem_pkg::fifo_depth);

  assign wr_pend = wa_valid && wd_valid;           // both heads present
  assign rd_pend = run_q && ar_valid && credit_ok; // room guaranteed for the beat

  // tie goes to whoever did not win last time
  assign wr_go = wr_pend && !(rd_pend && prefer_rd);
  assign rd_go = rd_pend && !(wr_pend && !prefer_rd);

  // address and data pop together
  assign wa_ready = wr_go;
  assign wd_ready = wr_go;
  assign ar_ready = rd_go;

  // write side, slot came in with the address
  assign mem_we         = wr_go;
  assign mem_waddr.slot = wa_data.slot;
  assign mem_waddr.word = wa_data.addr[mem_pkg::mem_addr_w-1:0]; // high bits dropped
  assign mem_wbeat      = wd_data;

  // read side always looks at the frame not being written
  assign mem_re         = rd_go;
  assign mem_raddr.slot = ~frame_sync;
  assign mem_raddr.word = rd_req.addr[mem_pkg::mem_addr_w-1:0];
  assign mem_rlast      = rd_req.last;

  always_ff @(posedge clk_ui) begin
    if (!rst_n) begin
      frame_q1   <= 1'b0;
      frame_sync <= 1'b0;
      run_q      <= 1'b0;
      prefer_rd  <= 1'b0;
      inflight_q <= 1'b0;
    end else begin
      frame_q1   <= frame_in;
      frame_sync <= frame_q1;
      run_q      <= 1'b1;
      inflight_q <= rd_go; // memory answers one cycle later
      if (wr_pend && rd_pend) begin
        prefer_rd <= ~prefer_rd; // flip only on contention
      end
    end
  end

  // memory port is single, one access per cycle
  a_one_access: assert property (
    @(posedge clk_ui) disable iff (!rst_n)
    !(mem_we && mem_re)
  );

  // reads outstanding never exceed read FIFO space
  a_credit_bound: assert property (
    @(posedge clk_ui) disable iff (!rst_n)
    credit_used <= (mem_pkg::cnt_w + 1)'(mem_pkg::fifo_depth)
  );

endmodule

`default_nettype wire

// ==== burst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_mem (
  input  wire                          clk_ui,
  input  wire                          rst_n,
  input  wire                          we,
  input  wire frame_pkg::mem_word_t    waddr,
  input  wire mem_pkg::wr_beat_t       wbeat,
  input  wire                          re,
  input  wire frame_pkg::mem_word_t    raddr,
  input  wire                          rlast,
  output mem_pkg::rd_beat_t            rd_beat,
  output logic                         beat_valid
);

  // two slots back to back, slot is the top address bit
  logic [mem_pkg::data_w-1:0] mem [2 ** (mem_pkg::mem_addr_w + 1)];

  initial begin
    for (int i = 0; i < 2 ** (mem_pkg::mem_addr_w + 1); i++) begin
      mem[i] = '0; // memory comes up cleared
    end
  end

  always @(posedge clk_ui) begin
    if (we) begin
      for (int b = 0; b < mem_pkg::strb_w; b++) begin
        if (wbeat.strb[b]) begin
          mem[waddr][b*8 +: 8] <= wbeat.data[b*8 +: 8]; // byte merge
        end
      end
    end
  end

  always_ff @(posedge clk_ui) begin
    if (re) begin
      rd_beat.data <= mem[raddr]; // old data if written same edge
      rd_beat.last <= rlast;
    end
  end

  always_ff @(posedge clk_ui) begin
    if (!rst_n) begin
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= re; // fixed one-cycle latency
    end
  end

  a_single_port: assert property (
    @(posedge clk_ui) disable iff (!rst_n)
    !(we && re)
  );

endmodule

`default_nettype wire

// ==== frame_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top (
  input  wire                                 clk_ui,
  input  wire                                 rst_n,
  input  wire                                 frame_in,
  input  wire mem_pkg::wr_beat_t              wr_beat,
  input  wire                                 wr_valid,
  output logic                                wr_ready,
  input  wire [frame_pkg::addr_w-1:0]         wr_addr,
  input  wire                                 aw_valid,
  output logic                                aw_ready,
  input  wire frame_pkg::rd_req_t             rd_req,
  input  wire                                 ar_valid,
  output logic                                ar_ready,
  output mem_pkg::rd_beat_t                   rd_data,
  output logic                                rd_valid,
  input  wire                                 rd_ready
);

  frame_pkg::wr_addr_t          aw_in;        // address tagged with raw frame_in
  frame_pkg::wr_addr_t          wa_data;
  logic                         wa_valid;
  logic                         wa_ready;
  mem_pkg::wr_beat_t            wd_data;
  logic                         wd_valid;
  logic                         wd_ready;
  logic [mem_pkg::cnt_w-1:0]    rfifo_count;  // feeds read credits
  logic                         mem_we;
  frame_pkg::mem_word_t         mem_waddr;
  mem_pkg::wr_beat_t            mem_wbeat;
  logic                         mem_re;
  frame_pkg::mem_word_t         mem_raddr;
  logic                         mem_rlast;
  mem_pkg::rd_beat_t            mem_rbeat;
  logic                         beat_valid;

  assign aw_in = '{slot: frame_in, addr: wr_addr}; // slot sampled unsynchronized

  beat_fifo #(
    .payload_t (mem_pkg::wr_beat_t),
    .depth     (mem_pkg::fifo_depth)
  ) wd_fifo_i (
    .clk_ui    (clk_ui),
    .rst_n     (rst_n),
    .in_data   (wr_beat),
    .in_valid  (wr_valid),
    .in_ready  (wr_ready),
    .out_data  (wd_data),
    .out_valid (wd_valid),
    .out_ready (wd_ready),
    .count     ()
  );

  beat_fifo #(
    .payload_t (frame_pkg::wr_addr_t),
    .depth     (mem_pkg::fifo_depth)
  ) wa_fifo_i (
    .clk_ui    (clk_ui),
    .rst_n     (rst_n),
    .in_data   (aw_in),
    .in_valid  (aw_valid),
    .in_ready  (aw_ready),
    .out_data  (wa_data),
    .out_valid (wa_valid),
    .out_ready (wa_ready),
    .count     ()
  );

  buffer_ctrl ctrl_i (
    .clk_ui      (clk_ui),
    .rst_n       (rst_n),
    .frame_in    (frame_in),
    .wa_data     (wa_data),
    .wa_valid    (wa_valid),
    .wa_ready    (wa_ready),
    .wd_data     (wd_data),
    .wd_valid    (wd_valid),
    .wd_ready    (wd_ready),
    .rd_req      (rd_req),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .rfifo_count (rfifo_count),
    .mem_we      (mem_we),
    .mem_waddr   (mem_waddr),
    .mem_wbeat   (mem_wbeat),
    .mem_re      (mem_re),
    .mem_raddr   (mem_raddr),
    .mem_rlast   (mem_rlast)
  );

  burst_mem mem_i (
    .clk_ui     (clk_ui),
    .rst_n      (rst_n),
    .we         (mem_we),
    .waddr      (mem_waddr),
    .wbeat      (mem_wbeat),
    .re         (mem_re),
    .raddr      (mem_raddr),
    .rlast      (mem_rlast),
    .rd_beat    (mem_rbeat),
    .beat_valid (beat_valid)
  );

  // credits keep this FIFO from overflowing, so its ready is not needed
  beat_fifo #(
    .payload_t (mem_pkg::rd_beat_t),
    .depth     (mem_pkg::fifo_depth)
  ) rd_fifo_i (
    .clk_ui    (clk_ui),
    .rst_n     (rst_n),
    .in_data   (mem_rbeat),
    .in_valid  (beat_valid),
    .in_ready  (),
    .out_data  (rd_data),
    .out_valid (rd_valid),
    .out_ready (rd_ready),
    .count     (rfifo_count)
  );

endmodule

`default_nettype wire

// ==== tb_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frame_buffer;

  localparam int n_beats     = 32;          // pool size, also beats per phase
  localparam int total_beats = 13 * n_beats; // all write and read beats over tests 2..6

  logic                           clk_ui;
  logic                           rst_n;
  logic                           frame_in;
  mem_pkg::wr_beat_t              wr_beat;
  logic                           wr_valid;
  logic                           wr_ready;
  logic [frame_pkg::addr_w-1:0]   wr_addr;
  logic                           aw_valid;
  logic                           aw_ready;
  frame_pkg::rd_req_t             rd_req;
  logic                           ar_valid;
  logic                           ar_ready;
  mem_pkg::rd_beat_t              rd_data;
  logic                           rd_valid;
  logic                           rd_ready;

  int                             seed = 8;
  int                             n_checks;
  int                             n_errors;
  int                             n_tests;
  int                             n_failed;
  int                             errs_start;
  logic [frame_pkg::addr_w-1:0]   pool [n_beats];  // addresses shared by all tests
  logic [mem_pkg::data_w-1:0]     model_mem [int]; // key is {slot, word}
  logic [frame_pkg::addr_w-1:0]   wa_q [$];        // pending write addresses
  mem_pkg::wr_beat_t              wd_q [$];        // pending write beats
  frame_pkg::rd_req_t             rq [$];          // pending read requests
  mem_pkg::rd_beat_t              rexp [$];        // expected beat per request
  mem_pkg::rd_beat_t              exp_q [$];       // accepted, beat still owed

  frame_buffer_top dut_i (
    .clk_ui   (clk_ui),
    .rst_n    (rst_n),
    .frame_in (frame_in),
    .wr_beat  (wr_beat),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .wr_addr  (wr_addr),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .rd_req   (rd_req),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready)
  );

  initial begin
    clk_ui = 1'b0;
    forever #50 clk_ui = ~clk_ui; // 100 ns period
  end

  initial begin
    repeat (total_beats * 40 + 2000) @(posedge clk_ui);
    $display("timeout: traffic did not drain within %0d cycles", total_beats * 40 + 2000);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_beat(input mem_pkg::rd_beat_t got, input mem_pkg::rd_beat_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t: read beat %h last %0b, expected %h last %0b",
               $time, got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_ready(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic logic [mem_pkg::data_w-1:0] model_read(input int key);
    return model_mem.exists(key) ? model_mem[key] : '0; // untouched words read zero
  endfunction

  task automatic model_write(input logic slot, input logic [frame_pkg::addr_w-1:0] a,
                             input mem_pkg::wr_beat_t b);
    int                         key;
    logic [mem_pkg::data_w-1:0] w;
    key = int'({slot, a[mem_pkg::mem_addr_w-1:0]}); // high address bits dropped
    w   = model_read(key);
    for (int i = 0; i < mem_pkg::strb_w; i++) begin
      if (b.strb[i]) w[i*8 +: 8] = b.data[i*8 +: 8];
    end
    model_mem[key] = w;
  endtask

  task automatic gen_writes(input int n, input bit partial);
    int                           r;
    logic [frame_pkg::addr_w-1:0] a;
    mem_pkg::wr_beat_t            b;
    for (int i = 0; i < n; i++) begin
      r      = $random(seed);
      a      = pool[r[4:0]];
      b.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      r      = $random(seed);
      b.strb = partial ? r[15:0] : '1;
      wa_q.push_back(a);
      wd_q.push_back(b);
      model_write(frame_in, a, b); // slot is the frame being written
    end
  endtask

  task automatic gen_reads(input int n);
    int                 r;
    frame_pkg::rd_req_t q;
    mem_pkg::rd_beat_t  e;
    for (int i = 0; i < n; i++) begin
      r      = $random(seed);
      q.addr = pool[r[4:0]];
      q.last = r[8];
      e.data = model_read(int'({~frame_in, q.addr[mem_pkg::mem_addr_w-1:0]})); // other slot
      e.last = r[8];
      rq.push_back(q);
      rexp.push_back(e);
    end
  endtask

  task automatic run_traffic(input bit gaps, input bit check_ar);
    int r;
    int wa_sent;
    int wd_sent;
    int rd_sent;
    bit wa_fire;
    bit wd_fire;
    bit ar_fire;
    wa_sent = 0;
    wd_sent = 0;
    rd_sent = 0;
    wa_fire = 1'b0;
    wd_fire = 1'b0;
    ar_fire = 1'b0;
    while (wa_sent < wa_q.size() || wd_sent < wd_q.size() || rd_sent < rq.size()
           || exp_q.size() != 0) begin
      @(negedge clk_ui);
      if (wa_fire) aw_valid = 1'b0; // accepted last edge
      if (wd_fire) wr_valid = 1'b0;
      if (ar_fire) ar_valid = 1'b0;
      r = $random(seed);
      if (!aw_valid && wa_sent < wa_q.size() && r[1:0] != 2'b00) begin
        aw_valid = 1'b1;
        wr_addr  = wa_q[wa_sent];
      end
      if (!wr_valid && wd_sent < wd_q.size() && r[3:2] != 2'b00) begin
        wr_valid = 1'b1;
        wr_beat  = wd_q[wd_sent];
      end
      if (!ar_valid && rd_sent < rq.size() && r[5:4] != 2'b00) begin
        ar_valid = 1'b1;
        rd_req   = rq[rd_sent];
      end
      rd_ready = gaps ? (r[7:6] == 2'b00) : 1'b1; // heavy back-pressure with gaps
      #1; // outputs settled until the next rising edge
      wa_fire = aw_valid && aw_ready;
      wd_fire = wr_valid && wr_ready;
      ar_fire = ar_valid && ar_ready;
      if (check_ar) begin
        // only credits can hold a read back when no write is queued
        check_ready("ar_ready", ar_ready,
                    ar_valid && (exp_q.size() < mem_pkg::fifo_depth));
      end
      if (rd_valid && rd_ready) begin
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("[ERROR] %0t: read beat returned with no request outstanding", $time);
        end else begin
          check_beat(rd_data, exp_q.pop_front());
        end
      end
      if (wa_fire) wa_sent++;
      if (wd_fire) wd_sent++;
      if (ar_fire) begin
        exp_q.push_back(rexp[rd_sent]);
        rd_sent++;
      end
    end
    wa_q.delete();
    wd_q.delete();
    rq.delete();
    rexp.delete();
  endtask

  // idle long enough for the write FIFOs to empty, no stray beats allowed
  task automatic drain();
    @(negedge clk_ui);
    aw_valid = 1'b0;
    wr_valid = 1'b0;
    ar_valid = 1'b0;
    rd_ready = 1'b1;
    repeat (2 * mem_pkg::fifo_depth + 4) begin
      @(negedge clk_ui);
      #1;
      check_ready("rd_valid", rd_valid, 1'b0);
    end
  endtask

  task automatic set_frame(input logic v);
    @(negedge clk_ui);
    frame_in = v;
    repeat (4) @(negedge clk_ui); // past the two-flop sync
  endtask

  task automatic report_test(input string name, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      n_failed++;
      $display("test %0d %s: failed with %0d errors", n_tests, name, n_errors - errs_before);
    end
  endtask

  initial begin
    int r;
    rst_n    = 1'b0;
    frame_in = 1'b0;
    wr_beat  = '0;
    wr_valid = 1'b0;
    wr_addr  = '0;
    aw_valid = 1'b0;
    rd_req   = '0;
    ar_valid = 1'b0;
    rd_ready = 1'b0;
    n_checks = 0;
    n_errors = 0;
    n_tests  = 0;
    n_failed = 0;
    for (int i = 0; i < n_beats; i++) begin
      r       = $random(seed);
      pool[i] = r[frame_pkg::addr_w-1:0];
    end
    repeat (10) @(negedge clk_ui);
    rst_n = 1'b1;

    errs_start = n_errors;
    repeat (2) @(negedge clk_ui);
    #1;
    check_ready("aw_ready", aw_ready, 1'b1);
    check_ready("wr_ready", wr_ready, 1'b1);
    check_ready("rd_valid", rd_valid, 1'b0);
    report_test("reset state", errs_start);

    errs_start = n_errors;
    gen_writes(n_beats, 1'b0);
    run_traffic(1'b0, 1'b0);
    drain();
    set_frame(1'b1);
    gen_reads(n_beats);
    run_traffic(1'b0, 1'b1);
    drain();
    report_test("full strobe write and read back", errs_start);

    errs_start = n_errors;
    set_frame(1'b0);
    gen_writes(n_beats, 1'b1); // merge into slot 0 words
    run_traffic(1'b0, 1'b0);
    drain();
    set_frame(1'b1);
    gen_reads(n_beats);
    run_traffic(1'b0, 1'b1);
    drain();
    report_test("partial strobe merge", errs_start);

    errs_start = n_errors;
    gen_writes(n_beats, 1'b0); // slot 1, invisible while frame_in stays 1
    run_traffic(1'b0, 1'b0);
    drain();
    gen_reads(n_beats);
    run_traffic(1'b0, 1'b1);
    drain();
    set_frame(1'b0);
    gen_reads(n_beats);
    run_traffic(1'b0, 1'b1);
    drain();
    report_test("ping-pong slot isolation", errs_start);

    errs_start = n_errors;
    gen_reads(4 * n_beats);
    run_traffic(1'b1, 1'b1);
    drain();
    report_test("read stream under back-pressure", errs_start);

    errs_start = n_errors;
    gen_writes(n_beats, 1'b0); // slot 0 while reads hit slot 1
    gen_reads(n_beats);
    run_traffic(1'b0, 1'b0);
    drain();
    report_test("concurrent write and read", errs_start);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
mem_pkg.sv
frame_pkg.sv
beat_fifo.sv
buffer_ctrl.sv
burst_mem.sv
frame_buffer_top.sv
tb_frame_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_frame_buffer
out="$(./obj_dir/Vtb_frame_buffer)"
echo "$out"
if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
